/* common/cpuIsaPkg.sv */
// instruction set encoding shared by the core and the testbench
// fixes the word width, the field layout and the opcode and funct values
package cpuIsaPkg;

  // word and instruction width
  localparam int dataWidth = 16;

  // register file geometry
  localparam int regAddrWidth = 3;
  localparam int numRegs = 8;

  // JAL writes its return address here
  localparam logic [regAddrWidth-1:0] linkReg = 7;

  // instruction field positions
  localparam int opcodeHi = 15;
  localparam int opcodeLo = 13;
  localparam int rsHi = 12;
  localparam int rsLo = 10;
  localparam int rtHi = 9;
  localparam int rtLo = 7;
  localparam int rdHi = 6;
  localparam int rdLo = 4;
  localparam int functHi = 3;
  localparam int functLo = 0;
  localparam int immHi = 6;
  localparam int immLo = 0;
  localparam int jumpHi = 13;
  localparam int jumpLo = 0;

  // major opcodes, bits 15..13
  typedef enum logic [2:0] {
    opRtype = 3'd0,
    opSlti  = 3'd1,
    opJ     = 3'd2,
    opJal   = 3'd3,
    opLw    = 3'd4,
    opSw    = 3'd5,
    opBeq   = 3'd6,
    opAddi  = 3'd7
  } opcode_e;

  // R-type function codes, bits 3..0
  typedef enum logic [3:0] {
    fnAdd = 4'd0,
    fnSub = 4'd1,
    fnAnd = 4'd2,
    fnOr  = 4'd3,
    fnSlt = 4'd4,
    fnJr  = 4'd8
  } funct_e;

endpackage

/* common/cpuUarchPkg.sv */
// control encodings passed between the blocks inside the core
// plus the data memory geometry
package cpuUarchPkg;

  // operation performed by the ALU
  typedef enum logic [2:0] {
    aluAdd = 3'd0,
    aluSub = 3'd1,
    aluAnd = 3'd2,
    aluOr  = 3'd3,
    aluSlt = 3'd4
  } aluOp_e;

  // which field names the destination register
  typedef enum logic [1:0] {
    dstRt   = 2'd0,
    dstRd   = 2'd1,
    dstLink = 2'd2
  } regDst_e;

  // source of the register writeback value
  typedef enum logic [1:0] {
    wbAlu  = 2'd0,
    wbMem  = 2'd1,
    wbLink = 2'd2
  } wbSel_e;

  // data memory depth in words
  localparam int memWords = 256;

  // word index width, taken from byte address bits 8..1
  localparam int memAddrWidth = 8;

endpackage

/* dv/cpuTb.sv */
// testbench for the single-cycle core with clock, reset, instruction ROM and program
// all checking happens in the bound property module
module cpuTb
  import cpuIsaPkg::*;
();

  logic clk;
  logic reset;
  logic [dataWidth-1:0] imemAddr;
  logic [dataWidth-1:0] imemData;
  logic regWriteEn;
  logic [regAddrWidth-1:0] regWriteAddr;
  logic [dataWidth-1:0] regWriteData;

  logic [dataWidth-1:0] rom [256];
  logic [dataWidth-1:0] endAddr = 16'd40;
  int maxCycles = 200;
  int timeoutCount = 0;
  integer seed;

  cpuTop dut0 (
    .clk(clk), .reset(reset), .imemAddr(imemAddr), .imemData(imemData),
    .regWriteEn(regWriteEn), .regWriteAddr(regWriteAddr), .regWriteData(regWriteData)
  );

  bind cpuTop cpuTopProperties props (
    .clk(clk), .reset(reset), .imemAddr(imemAddr), .imemData(imemData),
    .regWriteEn(regWriteEn), .regWriteAddr(regWriteAddr), .regWriteData(regWriteData)
  );

  // instruction ROM, halfword addressed
  assign imemData = rom[imemAddr[8:1]];

  always #2 clk = ~clk;

  function automatic logic [15:0] encodeR(funct_e fn, logic [2:0] rs, logic [2:0] rt,
                                          logic [2:0] rd);
    return {opRtype, rs, rt, rd, fn};
  endfunction

  function automatic logic [15:0] encodeI(opcode_e op, logic [2:0] rs, logic [2:0] rt,
                                          logic [6:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // target is a byte address, only bits 13..1 fit beside the opcode
  function automatic logic [15:0] encodeJump(opcode_e op, logic [15:0] target);
    return {op, target[13:1]};
  endfunction

  task automatic loadProgram();
    logic [6:0] imm1, imm2, imm3, imm4;
    imm1 = 7'($random(seed));
    imm2 = 7'($random(seed));
    imm3 = 7'($random(seed));
    imm4 = 7'($random(seed));
    rom[0] <= encodeI(opAddi, 3'd0, 3'd1, imm1);
    rom[1] <= encodeI(opAddi, 3'd0, 3'd2, imm2);
    rom[2] <= encodeI(opAddi, 3'd1, 3'd3, imm3);
    rom[3] <= encodeR(fnAdd, 3'd1, 3'd2, 3'd4);
    rom[4] <= encodeR(fnSub, 3'd1, 3'd2, 3'd5);
    rom[5] <= encodeR(fnAnd, 3'd4, 3'd3, 3'd6);
    rom[6] <= encodeR(fnOr, 3'd5, 3'd6, 3'd4);
    rom[7] <= encodeR(fnSlt, 3'd1, 3'd2, 3'd5);
    rom[8] <= encodeI(opSlti, 3'd2, 3'd6, imm4);
    // base address 20 for the memory accesses
    rom[9] <= encodeI(opAddi, 3'd0, 3'd3, 7'd20);
    rom[10] <= encodeI(opSw, 3'd3, 3'd4, 7'd4);
    rom[11] <= encodeI(opLw, 3'd3, 3'd5, 7'd4);
    rom[12] <= encodeI(opSw, 3'd3, 3'd1, 7'h7e);
    rom[13] <= encodeI(opLw, 3'd3, 3'd6, 7'h7e);
    // r2 = r1 + 1 so the first BEQ falls through
    rom[14] <= encodeI(opAddi, 3'd1, 3'd2, 7'd1);
    rom[15] <= encodeI(opBeq, 3'd1, 3'd2, 7'd5);
    rom[16] <= encodeI(opBeq, 3'd1, 3'd1, 7'd1);
    rom[17] <= encodeI(opAddi, 3'd0, 3'd4, 7'd1);
    // JAL lands on the alias of word 24 with bit 14 set
    rom[18] <= encodeJump(opJal, 16'd48);
    rom[19] <= encodeR(fnAdd, 3'd7, 3'd0, 3'd1);
    rom[20] <= encodeJump(opJ, endAddr);
    // subroutine
    rom[24] <= encodeR(fnOr, 3'd7, 3'd0, 3'd3);
    rom[25] <= encodeR(fnJr, 3'd7, 3'd0, 3'd0);
  endtask

  // done once the PC sits on the end address for two edges in a row
  task automatic waitForEnd();
    int cycles;
    int hits;
    cycles = 0;
    hits = 0;
    while (hits < 2 && cycles < maxCycles) begin
      @(posedge clk);
      cycles++;
      if (imemAddr == endAddr) begin
        hits++;
      end else begin
        hits = 0;
      end
    end
    if (hits < 2) begin
      $display("program never reached its end address within %0d cycles", maxCycles);
      timeoutCount++;
    end
  endtask

  initial begin
    seed = 32'h2a90;
    clk = 1'b0;
    reset = 1'b1;
    // every unused word is a J to itself
    for (int i = 0; i < 256; i++) begin
      rom[i] = encodeJump(opJ, 16'(2 * i));
    end
    @(posedge clk);
    loadProgram();
    repeat (15) @(posedge clk);
    reset <= 1'b0;
    waitForEnd();
    @(negedge clk);
    $display("errors: %0d assertion failures, %0d timeouts",
             dut0.props.failCount, timeoutCount);
    if (dut0.props.failCount == 0 && timeoutCount == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* dv/cpuTop_properties.sv */
// shadow model and concurrent checks for the core, bound to cpuTop
// expected values follow the ISA rules applied to shadow registers and memory
module cpuTopProperties
  import cpuIsaPkg::*;
  import cpuUarchPkg::*;
(
  input logic                    clk,
  input logic                    reset,
  input logic [dataWidth-1:0]    imemAddr,
  input logic [dataWidth-1:0]    imemData,
  input logic                    regWriteEn,
  input logic [regAddrWidth-1:0] regWriteAddr,
  input logic [dataWidth-1:0]    regWriteData
);

  int failCount = 0;

  logic [dataWidth-1:0] shadowRegs [numRegs];
  logic [dataWidth-1:0] shadowMem [memWords];
  opcode_e opcode;
  funct_e funct;
  logic [regAddrWidth-1:0] rs, rt, rd, expWriteAddr;
  logic [dataWidth-1:0] rsVal, rtVal, immSext, immZext, pcPlus2, lsAddr;
  logic [dataWidth-1:0] expNextPc, prevExpNextPc, expWriteData;
  logic isFlow, checkWb, expWriteEn;

  assign opcode = opcode_e'(imemData[opcodeHi:opcodeLo]);
  assign funct = funct_e'(imemData[functHi:functLo]);
  assign rs = imemData[rsHi:rsLo];
  assign rt = imemData[rtHi:rtLo];
  assign rd = imemData[rdHi:rdLo];
  assign rsVal = (rs == '0) ? '0 : shadowRegs[rs];
  assign rtVal = (rt == '0) ? '0 : shadowRegs[rt];
  assign immSext = {{9{imemData[6]}}, imemData[6:0]};
  assign immZext = {9'd0, imemData[6:0]};
  assign pcPlus2 = imemAddr + 16'd2;
  assign lsAddr = rsVal + immSext;

  // reference decode of the instruction at the current PC
  always_comb begin
    isFlow = 1'b0;
    checkWb = 1'b1;
    expWriteEn = 1'b0;
    expWriteAddr = rt;
    expWriteData = '0;
    expNextPc = pcPlus2;
    case (opcode)
      opRtype: begin
        expWriteEn = 1'b1;
        expWriteAddr = rd;
        case (funct)
          fnAdd: expWriteData = rsVal + rtVal;
          fnSub: expWriteData = rsVal - rtVal;
          fnAnd: expWriteData = rsVal & rtVal;
          fnOr:  expWriteData = rsVal | rtVal;
          fnSlt: expWriteData = (rsVal < rtVal) ? 16'd1 : 16'd0;
          fnJr: begin
            isFlow = 1'b1;
            checkWb = 1'b0;
            expNextPc = rsVal;
          end
          default: checkWb = 1'b0;
        endcase
      end
      opSlti: begin
        expWriteEn = 1'b1;
        expWriteData = (rsVal < immZext) ? 16'd1 : 16'd0;
      end
      opJ, opJal: begin
        isFlow = 1'b1;
        expNextPc = {pcPlus2[15], imemData[13:0], 1'b0};
        if (opcode == opJal) begin
          expWriteEn = 1'b1;
          expWriteAddr = linkReg;
          expWriteData = pcPlus2;
        end
      end
      opLw: begin
        expWriteEn = 1'b1;
        expWriteData = shadowMem[lsAddr[memAddrWidth:1]];
      end
      opBeq: begin
        isFlow = 1'b1;
        if (rsVal == rtVal) begin
          expNextPc = pcPlus2 + {immSext[14:0], 1'b0};
        end
      end
      opAddi: begin
        expWriteEn = 1'b1;
        expWriteData = rsVal + immSext;
      end
      default: expWriteEn = 1'b0;
    endcase
  end

  always @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < numRegs; i++) begin
        shadowRegs[i] <= '0;
      end
    end else if (regWriteEn) begin
      shadowRegs[regWriteAddr] <= regWriteData;
    end
  end

  initial begin
    for (int i = 0; i < memWords; i++) begin
      shadowMem[i] = '0;
    end
  end

  always @(posedge clk) begin
    if (!reset && opcode == opSw) begin
      shadowMem[lsAddr[memAddrWidth:1]] <= rtVal;
    end
    prevExpNextPc <= expNextPc;
  end

  resetIdle: assert property (@(posedge clk) reset |-> imemAddr == '0 && !regWriteEn)
    else begin
      $error("error resetIdle: expected addr 0000 no write, actual addr %h write %b",
             $sampled(imemAddr), $sampled(regWriteEn));
      failCount++;
    end

  releasePc: assert property (@(posedge clk) $fell(reset) |-> imemAddr == '0)
    else begin
      $error("error releasePc: expected 0000 actual %h", $sampled(imemAddr));
      failCount++;
    end

  // no instruction retires on the edge that releases reset
  // sequential flow, PC+2
  seqPc: assert property (@(posedge clk) disable iff (reset)
                          !reset && !isFlow |=> imemAddr == prevExpNextPc)
    else begin
      $error("error seqPc: expected %h actual %h",
             $sampled(prevExpNextPc), $sampled(imemAddr));
      failCount++;
    end

  // BEQ, J, JAL and JR
  flowPc: assert property (@(posedge clk) disable iff (reset)
                           !reset && isFlow |=> imemAddr == prevExpNextPc)
    else begin
      $error("error flowPc: expected %h actual %h",
             $sampled(prevExpNextPc), $sampled(imemAddr));
      failCount++;
    end

  writeEnable: assert property (@(posedge clk) disable iff (reset)
                                !reset && checkWb |-> regWriteEn == expWriteEn)
    else begin
      $error("error writeEnable: expected %b actual %b",
             $sampled(expWriteEn), $sampled(regWriteEn));
      failCount++;
    end

  writeAddr: assert property (@(posedge clk) disable iff (reset)
                              !reset && checkWb && expWriteEn |->
                              regWriteAddr == expWriteAddr)
    else begin
      $error("error writeAddr: expected %0d actual %0d",
             $sampled(expWriteAddr), $sampled(regWriteAddr));
      failCount++;
    end

  writeData: assert property (@(posedge clk) disable iff (reset)
                              !reset && checkWb && expWriteEn |->
                              regWriteData == expWriteData)
    else begin
      $error("error writeData: expected %h actual %h",
             $sampled(expWriteData), $sampled(regWriteData));
      failCount++;
    end

endmodule

/* hdl/alu.sv */
// 16-bit ALU for add, sub, and, or and unsigned set-less-than
// zero flag feeds the BEQ decision
module alu
  import cpuIsaPkg::*;
  import cpuUarchPkg::*;
(
  input  logic [dataWidth-1:0] a,
  input  logic [dataWidth-1:0] b,
  input  aluOp_e               aluOp,
  output logic [dataWidth-1:0] result,
  output logic                 zero
);

  always_comb begin
    case (aluOp)
      aluSub: result = a - b;
      aluAnd: result = a & b;
      aluOr:  result = a | b;
      // unsigned compare, result is 0 or 1
      aluSlt: result = {{(dataWidth-1){1'b0}}, a < b};
      default: result = a + b;
    endcase
  end

  assign zero = (result == '0);

endmodule

/* hdl/controlUnit.sv */
// main decoder of the core; turns opcode and funct into datapath controls
// and picks the ALU operation and the JR redirect for R-type
module controlUnit
  import cpuIsaPkg::*;
  import cpuUarchPkg::*;
(
  input  logic    reset,
  input  opcode_e opcode,
  input  funct_e  funct,
  output regDst_e regDst,
  output wbSel_e  wbSel,
  output aluOp_e  aluOp,
  output logic    aluSrcImm,
  output logic    signExtend,
  output logic    memRead,
  output logic    memWrite,
  output logic    regWrite,
  output logic    branch,
  output logic    jump,
  output logic    jumpReg
);

  always_comb begin
    regDst = dstRt;
    wbSel = wbAlu;
    aluOp = aluAdd;
    aluSrcImm = 1'b0;
    signExtend = 1'b1;
    memRead = 1'b0;
    memWrite = 1'b0;
    regWrite = 1'b0;
    branch = 1'b0;
    jump = 1'b0;
    jumpReg = 1'b0;

    // all enables stay off while in reset
    if (!reset) begin
      case (opcode)
        opRtype: begin
          regDst = dstRd;
          regWrite = 1'b1;
          case (funct)
            fnSub: aluOp = aluSub;
            fnAnd: aluOp = aluAnd;
            fnOr:  aluOp = aluOr;
            fnSlt: aluOp = aluSlt;
            // JR still writes rd with the add result
            fnJr:  jumpReg = 1'b1;
            default: aluOp = aluAdd;
          endcase
        end
        opSlti: begin
          aluOp = aluSlt;
          aluSrcImm = 1'b1;
          signExtend = 1'b0;
          regWrite = 1'b1;
        end
        opJ: begin
          jump = 1'b1;
        end
        opJal: begin
          regDst = dstLink;
          wbSel = wbLink;
          jump = 1'b1;
          regWrite = 1'b1;
        end
        opLw: begin
          wbSel = wbMem;
          aluSrcImm = 1'b1;
          memRead = 1'b1;
          regWrite = 1'b1;
        end
        opSw: begin
          aluSrcImm = 1'b1;
          memWrite = 1'b1;
        end
        opBeq: begin
          aluOp = aluSub;
          branch = 1'b1;
        end
        opAddi: begin
          aluSrcImm = 1'b1;
          regWrite = 1'b1;
        end
      endcase
    end
  end

endmodule

/* hdl/cpuTop.sv */
// single-cycle 16-bit core; fetches through imemAddr/imemData and
// reports every register write on the writeback port
module cpuTop
  import cpuIsaPkg::*;
  import cpuUarchPkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  output logic [dataWidth-1:0]    imemAddr,
  input  logic [dataWidth-1:0]    imemData,
  output logic                    regWriteEn,
  output logic [regAddrWidth-1:0] regWriteAddr,
  output logic [dataWidth-1:0]    regWriteData
);

  opcode_e opcode;
  funct_e funct;
  regDst_e regDst;
  wbSel_e wbSel;
  aluOp_e aluOp;
  logic aluSrcImm, signExtend, memRead, memWrite, regWrite;
  logic branch, jump, jumpReg, zero;
  logic [regAddrWidth-1:0] rs, rt, rd;
  logic [dataWidth-1:0] pc, pcPlus2, immExt, aluB, aluResult;
  logic [dataWidth-1:0] readData1, readData2, memReadData;

  // instruction fields
  assign opcode = opcode_e'(imemData[opcodeHi:opcodeLo]);
  assign funct = funct_e'(imemData[functHi:functLo]);
  assign rs = imemData[rsHi:rsLo];
  assign rt = imemData[rtHi:rtLo];
  assign rd = imemData[rdHi:rdLo];

  // SLTI takes its immediate zero-extended
  assign immExt = signExtend ?
    {{(dataWidth-immHi-1){imemData[immHi]}}, imemData[immHi:immLo]} :
    {{(dataWidth-immHi-1){1'b0}}, imemData[immHi:immLo]};

  assign aluB = aluSrcImm ? immExt : readData2;

  // destination and writeback selects
  assign regWriteAddr = (regDst == dstLink) ? linkReg :
                        (regDst == dstRd)   ? rd : rt;
  assign regWriteData = (wbSel == wbLink) ? pcPlus2 :
                        (wbSel == wbMem)  ? memReadData : aluResult;
  assign regWriteEn = regWrite;
  assign imemAddr = pc;

  controlUnit uControl (
    .reset(reset), .opcode(opcode), .funct(funct),
    .regDst(regDst), .wbSel(wbSel), .aluOp(aluOp),
    .aluSrcImm(aluSrcImm), .signExtend(signExtend),
    .memRead(memRead), .memWrite(memWrite), .regWrite(regWrite),
    .branch(branch), .jump(jump), .jumpReg(jumpReg)
  );

  registerFile uRegs (
    .clk(clk), .reset(reset), .writeEn(regWrite), .writeAddr(regWriteAddr),
    .writeData(regWriteData), .readAddr1(rs), .readAddr2(rt),
    .readData1(readData1), .readData2(readData2)
  );

  alu uAlu (.a(readData1), .b(aluB), .aluOp(aluOp), .result(aluResult), .zero(zero));

  pcUnit uPc (
    .clk(clk), .reset(reset), .branch(branch), .jump(jump), .jumpReg(jumpReg),
    .zero(zero), .immExt(immExt), .jumpField(imemData[jumpHi:jumpLo]),
    .regTarget(readData1), .pc(pc), .pcPlus2(pcPlus2)
  );

  dataMemory uDmem (
    .clk(clk), .writeEn(memWrite), .readEn(memRead), .addr(aluResult),
    .writeData(readData2), .readData(memReadData)
  );

endmodule

/* hdl/dataMemory.sv */
// 256-word data memory, byte address with the word index in bits 8..1
// clocked write, combinational read that returns zero when not enabled
module dataMemory
  import cpuIsaPkg::*;
  import cpuUarchPkg::*;
(
  input  logic                 clk,
  input  logic                 writeEn,
  input  logic                 readEn,
  input  logic [dataWidth-1:0] addr,
  input  logic [dataWidth-1:0] writeData,
  output logic [dataWidth-1:0] readData
);

  logic [dataWidth-1:0] mem [memWords];
  logic [memAddrWidth-1:0] wordIndex;

  // starts out all zero
  initial begin
    for (int i = 0; i < memWords; i++) begin
      mem[i] = '0;
    end
  end

  assign wordIndex = addr[memAddrWidth:1];

  always_ff @(posedge clk) begin
    if (writeEn) begin
      mem[wordIndex] <= writeData;
    end
  end

  assign readData = readEn ? mem[wordIndex] : '0;

endmodule

/* hdl/pcUnit.sv */
// program counter and next-PC selection
// priority is JR, then J/JAL, then taken BEQ, then PC+2
module pcUnit
  import cpuIsaPkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 branch,
  input  logic                 jump,
  input  logic                 jumpReg,
  input  logic                 zero,
  input  logic [dataWidth-1:0] immExt,
  input  logic [jumpHi:jumpLo] jumpField,
  input  logic [dataWidth-1:0] regTarget,
  output logic [dataWidth-1:0] pc,
  output logic [dataWidth-1:0] pcPlus2
);

  logic [dataWidth-1:0] branchTarget, jumpTarget, nextPc;

  assign pcPlus2 = pc + dataWidth'(2);

  // halfword offset relative to PC+2
  assign branchTarget = pcPlus2 + {immExt[dataWidth-2:0], 1'b0};

  // top bit kept from PC+2, low bit always 0
  assign jumpTarget = {pcPlus2[dataWidth-1], jumpField, 1'b0};

  always_comb begin
    if (jumpReg) begin
      nextPc = regTarget;
    end else if (jump) begin
      nextPc = jumpTarget;
    end else if (branch && zero) begin
      nextPc = branchTarget;
    end else begin
      nextPc = pcPlus2;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= '0;
    end else begin
      pc <= nextPc;
    end
  end

endmodule

/* hdl/registerFile.sv */
// 8 x 16 register file, two combinational reads and one clocked write
// register 0 accepts writes but always reads as zero
module registerFile
  import cpuIsaPkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    writeEn,
  input  logic [regAddrWidth-1:0] writeAddr,
  input  logic [dataWidth-1:0]    writeData,
  input  logic [regAddrWidth-1:0] readAddr1,
  input  logic [regAddrWidth-1:0] readAddr2,
  output logic [dataWidth-1:0]    readData1,
  output logic [dataWidth-1:0]    readData2
);

  logic [dataWidth-1:0] regs [numRegs];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn) begin
      regs[writeAddr] <= writeData;
    end
  end

  assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
  assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

/* sim.f */
common/cpuIsaPkg.sv
common/cpuUarchPkg.sv
hdl/alu.sv
hdl/controlUnit.sv
hdl/pcUnit.sv
hdl/registerFile.sv
hdl/dataMemory.sv
hdl/cpuTop.sv
dv/cpuTop_properties.sv
dv/cpuTb.sv
